// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= lsu_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: files.f
lsu_pkg.sv
lsu_agu.sv
lsu_dmem.sv
lsu_load_ext.sv
lsu_top.sv
lsu_tb.sv

// File: lsu_agu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_agu (
    input  logic              clock,
    input  logic              reset,
    input  logic              req_valid,
    output logic              req_ready,
    input  lsu_pkg::lsu_req_t req,
    output logic              mem_valid,
    input  logic              mem_ready,
    output lsu_pkg::mem_req_t mem
);
    import lsu_pkg::*;

    addr_t      addr;
    lane_t      lane;
    logic       f3_legal;
    logic       misaligned;
    logic       error;
    word_t      wdata;
    byte_mask_t mask;
    mem_req_t   mem_next;

    assign addr = req.base + {{20{req.imm[11]}}, req.imm};
    assign lane = addr[1:0];

    // unsigned variants exist only for loads.
    always_comb begin
        f3_legal   = 1'b0;
        misaligned = 1'b0;
        case (req.funct3)
            F3_B: begin
                f3_legal = 1'b1;
            end
            F3_BU: begin
                f3_legal = !req.is_store;
            end
            F3_H: begin
                f3_legal   = 1'b1;
                misaligned = lane[0];
            end
            F3_HU: begin
                f3_legal   = !req.is_store;
                misaligned = lane[0];
            end
            F3_W: begin
                f3_legal   = 1'b1;
                misaligned = |lane;
            end
            default: begin
                f3_legal = 1'b0;
            end
        endcase
    end

    assign error = !f3_legal || misaligned;

    //////////////////////////////
    // store lane placement
    //////////////////////////////

    always_comb begin
        wdata = '0;
        mask  = '0;
        if (req.is_store && !error) begin
            case (req.funct3)
                F3_B: begin
                    wdata = word_t'(req.store_data[7:0]) << {lane, 3'b000};
                    mask  = 4'b0001 << lane;
                end
                F3_H: begin
                    wdata = word_t'(req.store_data[15:0]) << {lane, 3'b000};
                    mask  = 4'b0011 << lane;
                end
                default: begin
                    wdata = req.store_data;
                    mask  = 4'b1111;
                end
            endcase
        end
    end

    always_comb begin
        mem_next.is_store  = req.is_store;
        mem_next.funct3    = req.funct3;
        mem_next.word_addr = addr >> 2;
        mem_next.lane      = lane;
        mem_next.wdata     = wdata;
        mem_next.mask      = mask;
        mem_next.error     = error;
    end

    assign req_ready = !mem_valid || mem_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            mem_valid <= 1'b0;
        end else if (req_ready) begin
            mem_valid <= req_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (req_valid && req_ready) begin
            mem <= mem_next;
        end
    end

endmodule

`default_nettype wire

// File: lsu_dmem.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_dmem #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                mem_valid,
    output logic                mem_ready,
    input  lsu_pkg::mem_req_t   mem,
    output logic                raw_valid,
    input  logic                raw_ready,
    output lsu_pkg::dmem_resp_t raw
);
    import lsu_pkg::*;

    localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    word_t            mem_array [DMEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             xfer;

    // addresses wrap around the array size.
    assign idx  = IDX_W'(mem.word_addr % DMEM_WORDS);
    assign xfer = mem_valid && mem_ready;

    // the output register can take a new item when empty or when it is drained this cycle.
    assign mem_ready = !raw_valid || raw_ready;

    //////////////////////////////
    // storage
    //////////////////////////////

    // an errored item carries an empty mask, so it writes nothing.
    always_ff @(posedge clock) begin
        if (xfer && mem.is_store) begin
            for (int i = 0; i < 4; i++) begin
                if (mem.mask[i]) begin
                    mem_array[idx][8*i +: 8] <= mem.wdata[8*i +: 8];
                end
            end
        end
    end

    //////////////////////////////
    // output register
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            raw_valid <= 1'b0;
        end else if (mem_ready) begin
            raw_valid <= mem_valid;
        end
    end

    // the read sees the word as it was before this edge.
    always_ff @(posedge clock) begin
        if (xfer) begin
            raw.rdata    <= mem_array[idx];
            raw.funct3   <= mem.funct3;
            raw.lane     <= mem.lane;
            raw.is_store <= mem.is_store;
            raw.error    <= mem.error;
        end
    end

endmodule

`default_nettype wire

// File: lsu_load_ext.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_ext (
    input  lsu_pkg::dmem_resp_t raw,
    output lsu_pkg::lsu_resp_t  resp
);
    import lsu_pkg::*;

    word_t shifted;
    word_t data;

    // bring the addressed lane down to bit zero.
    assign shifted = raw.rdata >> {raw.lane, 3'b000};

    always_comb begin
        case (raw.funct3)
            F3_B: begin
                data = {{24{shifted[7]}}, shifted[7:0]};
            end
            F3_H: begin
                data = {{16{shifted[15]}}, shifted[15:0]};
            end
            F3_W: begin
                data = raw.rdata;
            end
            F3_BU: begin
                data = {24'b0, shifted[7:0]};
            end
            F3_HU: begin
                data = {16'b0, shifted[15:0]};
            end
            default: begin
                data = '0;
            end
        endcase
    end

    // stores and failed accesses report no data.
    always_comb begin
        resp.data     = (raw.is_store || raw.error) ? '0 : data;
        resp.is_store = raw.is_store;
        resp.error    = raw.error;
    end

endmodule

`default_nettype wire

// File: lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    //////////////////////////////
    // widths with a meaning
    //////////////////////////////

    typedef logic [31:0]        word_t;
    typedef logic [31:0]        addr_t;
    typedef logic [2:0]         funct3_t;
    typedef logic [3:0]         byte_mask_t;
    typedef logic [1:0]         lane_t;
    typedef logic signed [11:0] imm_t;

    // width and sign codes as they appear in the load/store funct3 field.
    localparam funct3_t F3_B  = 3'b000;
    localparam funct3_t F3_H  = 3'b001;
    localparam funct3_t F3_W  = 3'b010;
    localparam funct3_t F3_BU = 3'b100;
    localparam funct3_t F3_HU = 3'b101;

    //////////////////////////////
    // stage payloads
    //////////////////////////////

    typedef struct packed {
        logic    is_store;
        funct3_t funct3;
        word_t   base;
        imm_t    imm;
        word_t   store_data;
    } lsu_req_t;

    // word_addr is the byte address shifted right by two.
    typedef struct packed {
        logic       is_store;
        funct3_t    funct3;
        addr_t      word_addr;
        lane_t      lane;
        word_t      wdata;
        byte_mask_t mask;
        logic       error;
    } mem_req_t;

    typedef struct packed {
        word_t   rdata;
        funct3_t funct3;
        lane_t   lane;
        logic    is_store;
        logic    error;
    } dmem_resp_t;

    typedef struct packed {
        word_t data;
        logic  is_store;
        logic  error;
    } lsu_resp_t;

endpackage

`default_nettype wire

// File: lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;
    import lsu_pkg::*;

    localparam int TB_WORDS   = 64;
    localparam int IDX_W      = $clog2(TB_WORDS);
    localparam int N_RANDOM   = 400;
    localparam int TOTAL_REQS = 128 + 72 + 26 + 20 + 9 + N_RANDOM;

    logic      clock;
    logic      reset;
    logic      req_valid;
    logic      req_ready;
    lsu_req_t  req;
    logic      resp_valid;
    logic      resp_ready = 1'b1;
    lsu_resp_t resp;

    word_t       model_mem [TB_WORDS];
    lsu_resp_t   exp_q [$];
    int          accept_q [$];
    int          cycle = 0;
    int          accepted = 0;
    logic        check_latency = 1'b1;
    logic        random_phase = 1'b0;
    logic [31:0] stim_state = 32'h2602;
    // the ready stream starts from the inverted seed.
    logic [31:0] ready_state = ~32'h2602;

    lsu_top #(.DMEM_WORDS(TB_WORDS)) dut_i (.*);

    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_random(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    //////////////////////////////
    // reference model
    //////////////////////////////

    // funct3[1:0] gives the access width and funct3[2] marks an unsigned load.
    function automatic lsu_resp_t model_access(input lsu_req_t r);
        addr_t            a;
        logic [IDX_W-1:0] idx;
        int               shift;
        word_t            lanes;
        word_t            sel;
        lsu_resp_t        e;
        a     = r.base + {{20{r.imm[11]}}, r.imm};
        idx   = a[IDX_W+1:2];
        shift = 8 * int'(a[1:0]);
        lanes = (r.funct3[1:0] == 2'b00) ? 32'hFF :
                (r.funct3[1:0] == 2'b01) ? 32'hFFFF : 32'hFFFF_FFFF;
        e.is_store = r.is_store;
        e.data     = '0;
        e.error    = (r.funct3[1:0] == 2'b11) || (r.funct3[2] && (r.is_store || r.funct3[1])) ||
                     (r.funct3[0] && a[0]) || (r.funct3[1] && a[1:0] != 2'b00);
        if (!e.error && r.is_store) begin
            lanes          = lanes << shift;
            model_mem[idx] = (model_mem[idx] & ~lanes) | ((r.store_data << shift) & lanes);
        end else if (!e.error) begin
            sel    = (model_mem[idx] >> shift) & lanes;
            e.data = sel;
            if (!r.funct3[2] && r.funct3[1:0] == 2'b00) begin
                e.data = {{24{sel[7]}}, sel[7:0]};
            end else if (!r.funct3[2] && r.funct3[1:0] == 2'b01) begin
                e.data = {{16{sel[15]}}, sel[15:0]};
            end
        end
        return e;
    endfunction

    //////////////////////////////
    // checker
    //////////////////////////////

    always @(posedge clock) begin
        lsu_resp_t expected;
        int        accept_cycle;
        if (!reset && resp_valid && resp_ready) begin
            assert (exp_q.size() != 0)
            else stop_with_failure("response received with no request outstanding");
            expected     = exp_q.pop_front();
            accept_cycle = accept_q.pop_front();
            assert (resp == expected)
            else stop_with_failure($sformatf("error at time %0t: got %h/%b/%b, expected %h/%b/%b",
                $time, resp.data, resp.is_store, resp.error,
                expected.data, expected.is_store, expected.error));
            // with resp_ready high a response leaves two edges after its request.
            assert (!check_latency || cycle == accept_cycle + 2)
            else stop_with_failure($sformatf("error at time %0t: response after %0d cycles",
                $time, cycle - accept_cycle));
        end
        if (!reset && req_valid && req_ready) begin
            exp_q.push_back(model_access(req));
            accept_q.push_back(cycle);
            accepted++;
        end
        cycle++;
    end

    always @(negedge clock) begin
        logic [31:0] rnd;
        rnd        = next_random(ready_state);
        resp_ready = random_phase ? (rnd[23:16] < 8'd180) : 1'b1;
    end

    initial begin
        repeat (20 * TOTAL_REQS + 200) @(posedge clock);
        stop_with_failure("timeout: responses missing");
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // the immediate is random and the base makes up the rest of the address.
    task automatic access(input logic is_store, input funct3_t f3, input addr_t a,
                          input word_t data);
        logic [31:0] rnd;
        int          target;
        rnd            = next_random(stim_state);
        req.is_store   = is_store;
        req.funct3     = f3;
        req.imm        = rnd[11:0];
        req.base       = a - {{20{rnd[11]}}, rnd[11:0]};
        req.store_data = data;
        req_valid      = 1'b1;
        target         = accepted + 1;
        while (accepted < target) begin
            @(negedge clock);
        end
    endtask

    task automatic drain();
        req_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clock);
        end
    endtask

    initial begin
        addr_t       a;
        logic [31:0] rnd;
        funct3_t     f3;
        int          v;
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (3) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        assert (req_ready && !resp_valid && !dut_i.mem_valid)
        else stop_with_failure("handshake signals not idle after reset");

        for (int i = 0; i < TB_WORDS; i++) begin
            a = 4 * i;
            access(1'b1, F3_W, a, a * 32'h9E37_79B1 + 32'h2545_F491);
        end
        // readback goes partly through addresses past the end of the array.
        for (int i = 0; i < TB_WORDS; i++) begin
            access(1'b0, F3_W, 4 * i + 256 * (i % 3), '0);
        end

        // four bytes, then two halfwords, each merged into a refilled word.
        for (int i = 0; i < 4; i++) begin
            a = 76 * i + 12;
            for (int ln = 0; ln < 6; ln++) begin
                access(1'b1, F3_W, a, a * 32'h9E37_79B1);
                access(1'b1, (ln < 4) ? F3_B : F3_H, a + ((ln < 4) ? ln : 2 * (ln - 4)),
                       next_random(stim_state));
                access(1'b0, F3_W, a, '0);
            end
        end

        for (int p = 0; p < 2; p++) begin
            a = 20 + 4 * p;
            access(1'b1, F3_W, a, (p == 0) ? 32'hF0E1_D2C3 : 32'h7061_5243);
            for (int ln = 0; ln < 4; ln++) begin
                access(1'b0, F3_B, a + ln, '0);
                access(1'b0, F3_BU, a + ln, '0);
                if (ln % 2 == 0) begin
                    access(1'b0, F3_H, a + ln, '0);
                    access(1'b0, F3_HU, a + ln, '0);
                end
            end
        end

        a = 40;
        access(1'b1, F3_W, a, 32'h1234_5678);
        for (int ln = 1; ln < 4; ln++) begin
            access(1'b0, F3_W, a + ln, '0);
            access(1'b1, F3_W, a + ln, 32'hFFFF_FFFF);
            if (ln % 2 == 1) begin
                access(1'b0, F3_H, a + ln, '0);
                access(1'b1, F3_H, a + ln, 32'hFFFF_FFFF);
            end
        end
        for (int f = 3; f < 8; f++) begin
            access(1'b1, funct3_t'(f), a, 32'hFFFF_FFFF);
            if (f != 4 && f != 5) begin
                access(1'b0, funct3_t'(f), a, '0);
            end
        end
        access(1'b0, F3_W, a, '0);

        drain();
        access(1'b0, F3_W, 32'd8, '0);
        drain();
        for (int i = 0; i < 8; i++) begin
            access(1'b0, F3_W, 4 * i, '0);
        end
        drain();

        check_latency = 1'b0;
        random_phase  = 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            rnd = next_random(stim_state);
            if (rnd[31:30] == 2'b00) begin
                req_valid = 1'b0;
                repeat (int'(rnd[29:28]) + 1) @(negedge clock);
            end
            // one code in eight is fully random and may be illegal.
            v  = int'(rnd[27:25]) % 5;
            f3 = (rnd[27:25] == 3'b111) ? rnd[24:22] : funct3_t'((v < 3) ? v : v + 1);
            a  = next_random(stim_state);
            if (rnd[21:20] != 2'b00) begin
                a = a & ~{30'b0, f3[1], f3[1] | f3[0]};
            end
            access(rnd[19], f3, a, next_random(stim_state));
        end
        drain();

        // a duplicated item would show up here as a stray response.
        repeat (4) @(negedge clock);
        assert (!resp_valid && req_ready && !dut_i.mem_valid)
        else stop_with_failure("pipeline not empty after the last response");
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
    parameter int DMEM_WORDS = 256
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               req_valid,
    output logic               req_ready,
    input  lsu_pkg::lsu_req_t  req,
    output logic               resp_valid,
    input  logic               resp_ready,
    output lsu_pkg::lsu_resp_t resp
);
    import lsu_pkg::*;

    logic       mem_valid;
    logic       mem_ready;
    mem_req_t   mem;
    dmem_resp_t raw;

    lsu_agu agu_i (
        .clock    (clock),
        .reset    (reset),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req      (req),
        .mem_valid(mem_valid),
        .mem_ready(mem_ready),
        .mem      (mem)
    );

    // the memory output register is the last stage, so its handshake is the response port.
    lsu_dmem #(
        .DMEM_WORDS(DMEM_WORDS)
    ) dmem_i (
        .clock    (clock),
        .reset    (reset),
        .mem_valid(mem_valid),
        .mem_ready(mem_ready),
        .mem      (mem),
        .raw_valid(resp_valid),
        .raw_ready(resp_ready),
        .raw      (raw)
    );

    lsu_load_ext load_ext_i (
        .raw (raw),
        .resp(resp)
    );

endmodule

`default_nettype wire
